// ==== sources.f ====
+incdir+.
mdu_pkg.sv
md_dispatch.sv
div_unit.sv
mul_unit.sv
wb_arbiter.sv
mdu_top.sv
tb_mdu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mdu
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f sources.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// ==== tb_mdu.sv ====
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module tb_mdu import mdu_pkg::*; ();

localparam int XLEN     = `MDU_XLEN;
localparam int TAG_W    = `MDU_TAG_W;
localparam int DIV_LAT  = `MDU_DIV_STEPS + 4;   // issue drive to wb_en
localparam int MUL_LAT  = `MDU_MUL_STEPS + 4;
localparam int N_RAND   = 400;
localparam int N_OPS    = N_RAND + 30;
localparam int LIMIT_NS = N_OPS * 40 * 4 + 1000;

typedef struct {
    logic [TAG_W-1:0] tag;
    md_op_t           op;
    logic [XLEN-1:0]  data;
    int               cyc;      // cycle count at the issue edge
    int               lat_lo;
    int               lat_hi;
} sb_entry_t;

logic             clk;
logic             rst;
logic             issue;
logic             stall;
md_op_t           op;
logic [XLEN-1:0]  src_a;
logic [XLEN-1:0]  src_b;
logic [TAG_W-1:0] rd;
logic             mul_busy;
logic             div_busy;
logic             wb_en;
logic [TAG_W-1:0] wb_rd;
logic [XLEN-1:0]  wb_data;

logic [TAG_W-1:0] tag_ctr;
sb_entry_t        sb[$];
int               cyc;
int               n_pass;
int               n_errors;
int               pass_mark;
int               err_mark;

mdu_top DUT (
    .clk      (clk),
    .rst      (rst),
    .issue    (issue),
    .op       (op),
    .src_a    (src_a),
    .src_b    (src_b),
    .rd       (rd),
    .stall    (stall),
    .mul_busy (mul_busy),
    .div_busy (div_busy),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
);

always #2 clk = ~clk;

always @(posedge clk)
    cyc <= cyc + 1;

task automatic report_failure(input string msg);
    n_errors++;
    $display("%s", msg);
endtask

task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] got);
    assert (got === exp) n_pass++;
    else begin
        n_errors++;
        $display("ERR %0d ns %s expected %h got %h", $time, name, exp, got);
    end
endtask

// m-extension rules with the riscv x/0 and min/-1 cases
function automatic logic [XLEN-1:0] model_result(input md_op_t o, input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] sa, sbx, ua, ub;
    logic [2*XLEN-1:0] p_ss, p_su, p_uu;
    logic [XLEN-1:0]   q_s, r_s, q_u, r_u;
    logic [XLEN-1:0]   ones;
    logic              ovf;
    sa   = {{XLEN{a[XLEN-1]}}, a};
    sbx  = {{XLEN{b[XLEN-1]}}, b};
    ua   = {{XLEN{1'b0}}, a};
    ub   = {{XLEN{1'b0}}, b};
    p_ss = sa * sbx;
    p_su = sa * ub;
    p_uu = ua * ub;
    ones = '1;
    ovf  = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == ones);
    q_s  = ones;            // divide by zero
    r_s  = a;
    q_u  = ones;
    r_u  = a;
    if (ovf) begin
        q_s = a;
        r_s = '0;
    end else if (b != '0) begin
        q_s = $signed(a) / $signed(b);
        r_s = $signed(a) % $signed(b);
    end
    if (b != '0) begin
        q_u = a / b;
        r_u = a % b;
    end
    case (o)
        MD_MUL:    return p_uu[XLEN-1:0];
        MD_MULH:   return p_ss[2*XLEN-1:XLEN];
        MD_MULHSU: return p_su[2*XLEN-1:XLEN];
        MD_MULHU:  return p_uu[2*XLEN-1:XLEN];
        MD_DIV:    return q_s;
        MD_DIVU:   return q_u;
        MD_REM:    return r_s;
        default:   return r_u;
    endcase
endfunction

function automatic logic [XLEN-1:0] pick_operand();
    logic [31:0]     r;
    logic [XLEN-1:0] v;
    r = $urandom();
    v = $urandom();
    case (r[3:0])
        4'd0: v = '0;
        4'd1: v = {1'b1, {(XLEN-1){1'b0}}};
        4'd2: v = '1;
        4'd3: v = XLEN'(r[7:4]);    // small divisors
        default: ;
    endcase
    return v;
endfunction

task automatic check_writeback();
    int        idx;
    int        lat;
    sb_entry_t e;
    idx = -1;
    foreach (sb[i]) begin
        if (idx < 0 && sb[i].tag == wb_rd)
            idx = i;
    end
    if (idx < 0) begin
        report_failure($sformatf("write-back to x%0d at %0d ns with nothing outstanding",
                                 wb_rd, $time));
    end else begin
        e = sb[idx];
        sb.delete(idx);
        lat = cyc - e.cyc - 1;
        check_value($sformatf("wb_data (%s x%0d)", e.op.name(), e.tag), e.data, wb_data);
        assert (lat >= e.lat_lo && lat <= e.lat_hi) n_pass++;
        else report_failure($sformatf("%s x%0d written back after %0d cycles, expected %0d",
                                      e.op.name(), e.tag, lat, e.lat_lo));
    end
endtask

always @(negedge clk) begin
    if (!rst && wb_en)
        check_writeback();
end

assert property (@(posedge clk) disable iff (rst)
    (issue && stall && !mul_busy && !div_busy) |=> !(mul_busy || div_busy))
    else report_failure("an issue under stall started a unit");

assert property (@(posedge clk) disable iff (rst)
    (issue && !stall && op[2] && !div_busy) |=> div_busy)
    else report_failure("divide issue to an idle divider was not accepted");

assert property (@(posedge clk) disable iff (rst)
    (issue && !stall && !op[2] && !mul_busy) |=> mul_busy)
    else report_failure("multiply issue to an idle multiplier was not accepted");

task automatic issue_op(input md_op_t o, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                        input int lo, input int hi, input bit expect_wb);
    sb_entry_t e;
    @(posedge clk);
    issue <= 1'b1;
    op    <= o;
    src_a <= a;
    src_b <= b;
    rd    <= tag_ctr;
    if (expect_wb) begin
        e.tag    = tag_ctr;
        e.op     = o;
        e.data   = model_result(o, a, b);
        e.cyc    = cyc;
        e.lat_lo = lo;
        e.lat_hi = hi;
        sb.push_back(e);
    end
    tag_ctr = tag_ctr + 1'b1;
    @(posedge clk);
    issue <= 1'b0;
endtask

task automatic wait_drain();
    int n;
    n = 0;
    while (sb.size() > 0 && n < 2 * DIV_LAT) begin
        @(negedge clk);
        n++;
    end
    if (sb.size() > 0) begin
        report_failure($sformatf("%0d operation(s) never written back", sb.size()));
        sb.delete();
    end
endtask

task automatic run_one(input md_op_t o, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    issue_op(o, a, b, o[2] ? DIV_LAT : MUL_LAT, o[2] ? DIV_LAT : MUL_LAT, 1'b1);
    wait_drain();
endtask

task automatic end_test(input string name);
    $display("test %s: %0d checks passed, %0d errors", name, n_pass - pass_mark,
             n_errors - err_mark);
    pass_mark = n_pass;
    err_mark  = n_errors;
endtask

initial begin
    md_op_t          o;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [31:0]     r;
    void'($urandom(32'h00a2_2eb2));
    clk       = 1'b0;
    rst       = 1'b1;
    issue     = 1'b0;
    stall     = 1'b0;
    op        = MD_MUL;
    src_a     = '0;
    src_b     = '0;
    rd        = '0;
    tag_ctr   = '0;
    cyc       = 0;
    n_pass    = 0;
    n_errors  = 0;
    pass_mark = 0;
    err_mark  = 0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    repeat (3) begin
        @(negedge clk);
        check_value("mul_busy", '0, XLEN'(mul_busy));
        check_value("div_busy", '0, XLEN'(div_busy));
        check_value("wb_en", '0, XLEN'(wb_en));
    end
    end_test("reset");

    run_one(MD_MUL, 32'd7, -32'sd3);
    run_one(MD_MUL, 32'h1234_5678, 32'h9abc_def0);
    run_one(MD_MULH, -32'sd5, 32'd3);
    run_one(MD_MULH, 32'h8000_0000, 32'h8000_0000);
    run_one(MD_MULHSU, -32'sd1, 32'hffff_ffff);
    run_one(MD_MULHSU, 32'h7fff_ffff, 32'h8000_0000);
    run_one(MD_MULHU, 32'hffff_ffff, 32'hffff_ffff);
    run_one(MD_DIV, -32'sd20, 32'd3);
    run_one(MD_DIV, 32'd20, -32'sd3);
    run_one(MD_DIVU, 32'd100, 32'd7);
    run_one(MD_REM, -32'sd20, 32'd3);
    run_one(MD_REM, 32'd20, -32'sd3);
    run_one(MD_REMU, 32'hffff_fff0, 32'd7);
    end_test("directed");

    run_one(MD_DIV, 32'd77, 32'd0);
    run_one(MD_DIVU, 32'hdead_beef, 32'd0);
    run_one(MD_REM, -32'sd77, 32'd0);
    run_one(MD_REMU, 32'hdead_beef, 32'd0);
    run_one(MD_DIV, 32'h8000_0000, 32'hffff_ffff);
    run_one(MD_REM, 32'h8000_0000, 32'hffff_ffff);
    end_test("div_corner");

    // mul issued to finish on the divider's done cycle and lose by one
    issue_op(MD_DIV, -32'sd1000, 32'd9, DIV_LAT, DIV_LAT, 1'b1);
    repeat (DIV_LAT - MUL_LAT - 2) @(posedge clk);
    issue_op(MD_MULHU, 32'hcafe_f00d, 32'h0bad_beef, MUL_LAT + 1, MUL_LAT + 1, 1'b1);
    wait_drain();
    issue_op(MD_DIV, 32'd12345, 32'd67, DIV_LAT, DIV_LAT, 1'b1);
    issue_op(MD_REM, 32'd999, 32'd5, 0, 0, 1'b0);       // divider busy
    issue_op(MD_MUL, 32'd3, 32'd5, MUL_LAT, MUL_LAT, 1'b1);
    issue_op(MD_MULH, 32'd6, 32'd7, 0, 0, 1'b0);        // multiplier busy
    wait_drain();
    repeat (2 * DIV_LAT) @(negedge clk);
    end_test("concurrency");

    @(posedge clk);
    stall <= 1'b1;
    issue <= 1'b1;
    op    <= MD_DIVU;
    src_a <= 32'd1000;
    src_b <= 32'd10;
    rd    <= tag_ctr;
    repeat (3) @(posedge clk);
    issue <= 1'b0;
    stall <= 1'b0;
    repeat (DIV_LAT + 4) begin
        @(negedge clk);
        check_value("div_busy", '0, XLEN'(div_busy));
        check_value("mul_busy", '0, XLEN'(mul_busy));
    end
    end_test("stall");

    repeat (N_RAND) begin
        r = $urandom();
        o = md_op_t'(r[2:0]);
        a = pick_operand();
        b = pick_operand();
        @(negedge clk);
        while (o[2] ? div_busy : mul_busy)
            @(negedge clk);
        // only a multiply can lose arbitration
        issue_op(o, a, b, o[2] ? DIV_LAT : MUL_LAT, o[2] ? DIV_LAT : MUL_LAT + 1, 1'b1);
    end
    wait_drain();
    end_test("random");

    $display("summary: %0d checks passed, %0d errors", n_pass, n_errors);
    if (n_errors == 0) begin
        $display("No errors");
    end else begin
        $display("Errors found");
    end
    $finish;
end

initial begin
    #(LIMIT_NS);
    $display("timeout: run exceeded %0d ns", LIMIT_NS);
    $display("Errors found");
    $finish;
end

endmodule

// ==== mdu_top.sv ====
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module mdu_top import mdu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue,
    input  md_op_t                op,
    input  logic [`MDU_XLEN-1:0]  src_a,
    input  logic [`MDU_XLEN-1:0]  src_b,
    input  logic [`MDU_TAG_W-1:0] rd,
    input  logic                  stall,
    output logic                  mul_busy,
    output logic                  div_busy,
    output logic                  wb_en,
    output logic [`MDU_TAG_W-1:0] wb_rd,
    output logic [`MDU_XLEN-1:0]  wb_data
);

logic                  mul_start;
logic                  div_start;
md_op_t                op_q;
logic [`MDU_XLEN-1:0]  a_q;
logic [`MDU_XLEN-1:0]  b_q;
logic [`MDU_TAG_W-1:0] rd_q;

logic                  div_done;
logic                  div_grant;
logic [`MDU_XLEN-1:0]  div_result;
logic [`MDU_TAG_W-1:0] div_tag;

logic                  mul_done;
logic                  mul_grant;
logic [`MDU_XLEN-1:0]  mul_result;
logic [`MDU_TAG_W-1:0] mul_tag;

md_dispatch u_dispatch (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .stall     (stall),
    .op        (op),
    .src_a     (src_a),
    .src_b     (src_b),
    .rd        (rd),
    .mul_busy  (mul_busy),
    .div_busy  (div_busy),
    .mul_start (mul_start),
    .div_start (div_start),
    .op_q      (op_q),
    .a_q       (a_q),
    .b_q       (b_q),
    .rd_q      (rd_q)
);

div_unit u_div (
    .clk    (clk),
    .rst    (rst),
    .start  (div_start),
    .op     (op_q),
    .a      (a_q),
    .b      (b_q),
    .rd     (rd_q),
    .grant  (div_grant),
    .busy   (div_busy),
    .done   (div_done),
    .result (div_result),
    .tag    (div_tag)
);

mul_unit u_mul (
    .clk    (clk),
    .rst    (rst),
    .start  (mul_start),
    .op     (op_q),
    .a      (a_q),
    .b      (b_q),
    .rd     (rd_q),
    .grant  (mul_grant),
    .busy   (mul_busy),
    .done   (mul_done),
    .result (mul_result),
    .tag    (mul_tag)
);

wb_arbiter u_arb (
    .clk        (clk),
    .rst        (rst),
    .div_done   (div_done),
    .div_result (div_result),
    .div_tag    (div_tag),
    .mul_done   (mul_done),
    .mul_result (mul_result),
    .mul_tag    (mul_tag),
    .div_grant  (div_grant),
    .mul_grant  (mul_grant),
    .wb_en      (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
);

endmodule

// ==== wb_arbiter.sv ====
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module wb_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  div_done,
    input  logic [`MDU_XLEN-1:0]  div_result,
    input  logic [`MDU_TAG_W-1:0] div_tag,
    input  logic                  mul_done,
    input  logic [`MDU_XLEN-1:0]  mul_result,
    input  logic [`MDU_TAG_W-1:0] mul_tag,
    output logic                  div_grant,
    output logic                  mul_grant,
    output logic                  wb_en,
    output logic [`MDU_TAG_W-1:0] wb_rd,
    output logic [`MDU_XLEN-1:0]  wb_data
);

logic [`MDU_TAG_W-1:0] win_rd;
logic [`MDU_XLEN-1:0]  win_data;

// divider first, multiplier waits a cycle at most
assign div_grant = div_done;
assign mul_grant = mul_done & ~div_done;

assign win_rd   = div_grant ? div_tag : mul_tag;
assign win_data = div_grant ? div_result : mul_result;

always_ff @(posedge clk or posedge rst) begin
    if (rst)
        wb_en <= 1'b0;
    else
        wb_en <= div_grant | mul_grant;
end

always_ff @(posedge clk) begin
    if (div_grant | mul_grant) begin
        wb_rd   <= win_rd;
        wb_data <= win_data;
    end
end

endmodule

// ==== mul_unit.sv ====
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module mul_unit import mdu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  md_op_t                op,
    input  logic [`MDU_XLEN-1:0]  a,
    input  logic [`MDU_XLEN-1:0]  b,
    input  logic [`MDU_TAG_W-1:0] rd,
    input  logic                  grant,
    output logic                  busy,
    output logic                  done,
    output logic [`MDU_XLEN-1:0]  result,
    output logic [`MDU_TAG_W-1:0] tag
);

localparam int XLEN  = `MDU_XLEN;
localparam int CNT_W = $clog2(`MDU_MUL_STEPS);
localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MDU_MUL_STEPS - 1);

mul_state_t state, next_state;

logic [CNT_W-1:0]  count;
md_op_t            op_r;
logic [2*XLEN-1:0] mcand;    // shifted left two per step
logic [XLEN-1:0]   mplier;   // shifted right two per step
logic [2*XLEN-1:0] acc;
logic              neg;

logic              a_neg;
logic              b_neg;
logic [XLEN-1:0]   a_mag;
logic [XLEN-1:0]   b_mag;
logic [2*XLEN-1:0] pp0;
logic [2*XLEN-1:0] pp1;
logic [2*XLEN-1:0] prod;

// mul keeps the low word either way, so treat it unsigned
assign a_neg = a[XLEN-1] & ((op == MD_MULH) || (op == MD_MULHSU));
assign b_neg = b[XLEN-1] & (op == MD_MULH);
assign a_mag = a_neg ? -a : a;
assign b_mag = b_neg ? -b : b;

assign pp0  = mplier[0] ? mcand : '0;
assign pp1  = mplier[1] ? {mcand[2*XLEN-2:0], 1'b0} : '0;
assign prod = neg ? -acc : acc;

always_comb begin
    next_state = state;
    case (state)
        MUL_IDLE: if (start)
            next_state = MUL_RUN;
        MUL_RUN: if (count == LAST_STEP)
            next_state = MUL_FIX;
        MUL_FIX: next_state = MUL_DONE;
        MUL_DONE: if (grant)
            next_state = MUL_IDLE;
        default: next_state = MUL_IDLE;
    endcase
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        state <= MUL_IDLE;
        count <= '0;
    end else begin
        state <= next_state;
        count <= (state == MUL_RUN) ? count + 1'b1 : '0;
    end
end

always_ff @(posedge clk) begin
    if (state == MUL_IDLE && start) begin
        op_r   <= op;
        tag    <= rd;
        neg    <= a_neg ^ b_neg;
        mcand  <= {{XLEN{1'b0}}, a_mag};
        mplier <= b_mag;
        acc    <= '0;
    end else if (state == MUL_RUN) begin
        acc    <= acc + pp0 + pp1;
        mcand  <= mcand << 2;
        mplier <= mplier >> 2;
    end else if (state == MUL_FIX) begin
        result <= (op_r == MD_MUL) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    end
end

assign done = (state == MUL_DONE);
assign busy = start | (state != MUL_IDLE);

endmodule

// ==== div_unit.sv ====
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module div_unit import mdu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  md_op_t                op,
    input  logic [`MDU_XLEN-1:0]  a,
    input  logic [`MDU_XLEN-1:0]  b,
    input  logic [`MDU_TAG_W-1:0] rd,
    input  logic                  grant,
    output logic                  busy,
    output logic                  done,
    output logic [`MDU_XLEN-1:0]  result,
    output logic [`MDU_TAG_W-1:0] tag
);

localparam int XLEN  = `MDU_XLEN;
localparam int CNT_W = $clog2(`MDU_DIV_STEPS);
localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`MDU_DIV_STEPS - 1);

div_state_t state, next_state;

logic [CNT_W-1:0] count;
md_op_t           op_r;

logic [XLEN-1:0]  dvd;       // dividend, consumed msb first
logic [XLEN:0]    dvs;       // divisor magnitude
logic [XLEN:0]    rem;       // partial remainder
logic [XLEN-1:0]  quo;
logic             sign_q;
logic             sign_r;

logic             is_signed;
logic [XLEN:0]    rem_shift;
logic             fits;

assign is_signed = (op_r == MD_DIV) || (op_r == MD_REM);
assign rem_shift = {rem[XLEN-1:0], dvd[XLEN-1]};
assign fits      = rem_shift >= dvs;

always_comb begin
    next_state = state;
    case (state)
        DIV_IDLE: if (start)
            next_state = DIV_INIT;
        DIV_INIT: next_state = DIV_RUN;
        DIV_RUN: if (count == LAST_STEP)
            next_state = DIV_DONE;
        DIV_DONE: if (grant)
            next_state = DIV_IDLE;
        default: next_state = DIV_IDLE;
    endcase
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        state <= DIV_IDLE;
        count <= '0;
    end else begin
        state <= next_state;
        if (state == DIV_RUN)
            count <= count + 1'b1;
        else
            count <= '0;
    end
end

always_ff @(posedge clk) begin
    case (state)
        DIV_IDLE: begin
            if (start) begin
                op_r <= op;
                tag  <= rd;
                dvd  <= a;
                dvs  <= {1'b0, b};
            end
        end
        DIV_INIT: begin
            rem <= '0;
            quo <= '0;
            if (is_signed) begin
                // zero divisor keeps the quotient positive -> all ones
                sign_q <= (dvd[XLEN-1] ^ dvs[XLEN-1]) & (|dvs);
                sign_r <= dvd[XLEN-1];
                dvd    <= dvd[XLEN-1] ? -dvd : dvd;
                dvs    <= {1'b0, dvs[XLEN-1] ? -dvs[XLEN-1:0] : dvs[XLEN-1:0]};
            end else begin
                sign_q <= 1'b0;
                sign_r <= 1'b0;
            end
        end
        DIV_RUN: begin
            dvd <= dvd << 1;
            rem <= fits ? rem_shift - dvs : rem_shift;
            quo <= {quo[XLEN-2:0], fits};
        end
        default: begin
        end
    endcase
end

// sign fixup on the held quotient and remainder
always_comb begin
    case (op_r)
        MD_DIV:  result = sign_q ? -quo : quo;
        MD_REM:  result = sign_r ? -rem[XLEN-1:0] : rem[XLEN-1:0];
        MD_REMU: result = rem[XLEN-1:0];
        default: result = quo;                    // divu
    endcase
end

assign done = (state == DIV_DONE);
assign busy = start | (state != DIV_IDLE);

endmodule

// ==== md_dispatch.sv ====
`timescale 1ns/1ps
`include "mdu_cfg.svh"

module md_dispatch import mdu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue,
    input  logic                  stall,
    input  md_op_t                op,
    input  logic [`MDU_XLEN-1:0]  src_a,
    input  logic [`MDU_XLEN-1:0]  src_b,
    input  logic [`MDU_TAG_W-1:0] rd,
    input  logic                  mul_busy,
    input  logic                  div_busy,
    output logic                  mul_start,
    output logic                  div_start,
    output md_op_t                op_q,
    output logic [`MDU_XLEN-1:0]  a_q,
    output logic [`MDU_XLEN-1:0]  b_q,
    output logic [`MDU_TAG_W-1:0] rd_q
);

logic is_div;
logic target_busy;
logic accept;

assign is_div      = op inside {MD_DIV, MD_DIVU, MD_REM, MD_REMU};
assign target_busy = is_div ? div_busy : mul_busy;
assign accept      = issue & ~stall & ~target_busy; // dropped otherwise

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        mul_start <= 1'b0;
        div_start <= 1'b0;
    end else begin
        mul_start <= accept & ~is_div;
        div_start <= accept & is_div;
    end
end

// operands stay put until the next accepted issue
always_ff @(posedge clk) begin
    if (accept) begin
        op_q <= op;
        a_q  <= src_a;
        b_q  <= src_b;
        rd_q <= rd;
    end
end

endmodule

// ==== mdu_pkg.sv ====
package mdu_pkg;

    // m-extension ops, encoded as funct3
    typedef enum logic [2:0] {
        MD_MUL    = 3'b000,
        MD_MULH   = 3'b001,
        MD_MULHSU = 3'b010,
        MD_MULHU  = 3'b011,
        MD_DIV    = 3'b100,
        MD_DIVU   = 3'b101,
        MD_REM    = 3'b110,
        MD_REMU   = 3'b111
    } md_op_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_INIT,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_FIX,
        MUL_DONE
    } mul_state_t;

endpackage

// ==== mdu_cfg.svh ====
`ifndef MDU_CFG_SVH
`define MDU_CFG_SVH

// data path width, rv32 only
`define MDU_XLEN 32

// destination register tag
`define MDU_TAG_W 5

// one quotient bit per step
`define MDU_DIV_STEPS 32

// two multiplier bits per step
`define MDU_MUL_STEPS 16

`endif
